// File: design/rv_params.svh
/*
 * Core width and multiplier latency macros
 * Register file geometry
 */

`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Datapath width, only 32 exercised so far
`define XLEN 32

// Cycles a MUL occupies EX, must be 2 or more
`define MUL_CYCLES 4

// Integer register file geometry
`define NUM_REGS   32
`define REG_ADDR_W 5

`endif

// File: design/rv_isa_pkg.sv
/*
 * RV32 opcode and funct constants for the decoded subset
 * R and I/B instruction format structs, instruction word union
 */

`default_nettype none

package rv_isa_pkg;

  // Major opcodes
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;

  // funct3 codes
  localparam logic [2:0] F3_ADD = 3'b000;  // ADD, SUB, MUL, ADDI
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // funct7 codes
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;
  localparam logic [6:0] F7_MUL  = 7'b0000001;  // M extension

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // Same bits seen as I-type or B-type
  typedef struct packed {
    logic [6:0] imm_hi;      // I imm[11:5] or B {imm[12], imm[10:5]}
    logic [4:0] rs2_or_imm;  // rs2 for branches, I imm[4:0] otherwise
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd_or_imm;   // B {imm[4:1], imm[11]}
    logic [6:0] opcode;
  } ib_fmt_t;

  typedef union packed {
    r_fmt_t  r;
    ib_fmt_t ib;
  } instr_u;

endpackage

`default_nettype wire

// File: design/rv_pipe_pkg.sv
/*
 * ALU operation encoding
 * ID/EX record, forwarding bus, write-back and redirect strobes
 */

`default_nettype none

`include "rv_params.svh"

package rv_pipe_pkg;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,  // Also the cleared value
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5,  // Signed compare
    ALU_MUL = 3'd6   // Iterative, holds EX
  } alu_op_e;

  // ID/EX register contents
  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       op_a;
    logic [`XLEN-1:0]       op_b;
    logic [`XLEN-1:0]       imm;
    logic [`REG_ADDR_W-1:0] rd;
    alu_op_e                alu_op;
    logic                   alu_src;    // 1 selects imm
    logic                   branch;
    logic                   branch_ne;  // BNE when set, BEQ otherwise
    logic                   reg_write;
    logic                   valid;
  } idex_t;

  // Result completing in EX this cycle
  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } fwd_t;

  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } wb_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire

// File: design/reg_file.sv
/*
 * Integer register file, 32 entries
 * Two asynchronous read ports, one write port, x0 tied to zero
 */

`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module reg_file (
  input  wire                    clk,
  input  wire                    reset_n,
  input  wire [`REG_ADDR_W-1:0]  rs1_addr,
  input  wire [`REG_ADDR_W-1:0]  rs2_addr,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data,
  input  wire rv_pipe_pkg::fwd_t wr
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // x0 is never written so it stays at its reset value
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.valid && (wr.rd != '0)) begin
      regs[wr.rd] <= wr.data;
    end
  end

  // Same-cycle bypass is done in decode, not here
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

`default_nettype wire

// File: design/decode_stage.sv
/*
 * Decode stage: field extraction and control generation
 * Immediate build, operand read with forwarding from EX
 */

`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module decode_stage (
  input  wire                      instr_valid,
  input  wire                      ready,
  input  wire [`XLEN-1:0]          instr_pc,
  input  wire rv_isa_pkg::instr_u  instr_word,
  input  wire [`XLEN-1:0]          rs1_data,
  input  wire [`XLEN-1:0]          rs2_data,
  input  wire rv_pipe_pkg::fwd_t   fwd,
  output logic [`REG_ADDR_W-1:0]   rs1_addr,
  output logic [`REG_ADDR_W-1:0]   rs2_addr,
  output rv_pipe_pkg::idex_t       id_out
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_b;
  logic             fwd_a;
  logic             fwd_b;

  // Register addresses sit at the same bits in every format used here
  assign rs1_addr = instr_word.r.rs1;
  assign rs2_addr = instr_word.r.rs2;

  assign imm_i = {{(`XLEN-12){instr_word.ib.imm_hi[6]}},
                  instr_word.ib.imm_hi, instr_word.ib.rs2_or_imm};

  // B imm {12, 11, 10:5, 4:1, 0}
  assign imm_b = {{(`XLEN-13){instr_word.ib.imm_hi[6]}}, instr_word.ib.imm_hi[6],
                  instr_word.ib.rd_or_imm[0], instr_word.ib.imm_hi[5:0],
                  instr_word.ib.rd_or_imm[4:1], 1'b0};

  // x0 never forwards
  assign fwd_a = fwd.valid && (fwd.rd != '0) && (fwd.rd == rs1_addr);
  assign fwd_b = fwd.valid && (fwd.rd != '0) && (fwd.rd == rs2_addr);

  always_comb begin
    id_out       = '0;  // Unknown encodings leave all controls low
    id_out.pc    = instr_pc;
    id_out.op_a  = fwd_a ? fwd.data : rs1_data;
    id_out.op_b  = fwd_b ? fwd.data : rs2_data;
    id_out.valid = instr_valid && ready;

    case (instr_word.r.opcode)
      OP_REG: begin
        id_out.reg_write = 1'b1;
        id_out.rd        = instr_word.r.rd;
        case ({instr_word.r.funct7, instr_word.r.funct3})
          {F7_BASE, F3_ADD}: id_out.alu_op = ALU_ADD;
          {F7_SUB, F3_ADD}:  id_out.alu_op = ALU_SUB;
          {F7_BASE, F3_AND}: id_out.alu_op = ALU_AND;
          {F7_BASE, F3_OR}:  id_out.alu_op = ALU_OR;
          {F7_BASE, F3_XOR}: id_out.alu_op = ALU_XOR;
          {F7_BASE, F3_SLT}: id_out.alu_op = ALU_SLT;
          {F7_MUL, F3_ADD}:  id_out.alu_op = ALU_MUL;
          default: begin
            id_out.reg_write = 1'b0;
            id_out.rd        = '0;
          end
        endcase
      end
      OP_IMM: begin
        if (instr_word.ib.funct3 == F3_ADD) begin  // ADDI only
          id_out.reg_write = 1'b1;
          id_out.rd        = instr_word.r.rd;
          id_out.alu_src   = 1'b1;
          id_out.imm       = imm_i;
        end
      end
      OP_BRANCH: begin
        id_out.imm = imm_b;
        if (instr_word.ib.funct3 == F3_BEQ) begin
          id_out.branch = 1'b1;
        end else if (instr_word.ib.funct3 == F3_BNE) begin
          id_out.branch    = 1'b1;
          id_out.branch_ne = 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: design/idex_register.sv
/*
 * ID/EX pipeline register
 * Hold keeps the entry, flush turns it into a bubble
 */

`timescale 1ns/1ps
`default_nettype none

module idex_register (
  input  wire                       clk,
  input  wire                       reset_n,
  input  wire                       hold,   // Multiply in progress
  input  wire                       flush,  // Taken branch in EX
  input  wire rv_pipe_pkg::idex_t   id_in,
  output rv_pipe_pkg::idex_t        ex_out
);

  import rv_pipe_pkg::*;

  idex_t bubble;

  // Data kept for visibility, destination and controls dropped
  always_comb begin
    bubble      = '0;
    bubble.pc   = id_in.pc;
    bubble.op_a = id_in.op_a;
    bubble.op_b = id_in.op_b;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ex_out <= '0;
    end else if (flush && !hold) begin  // Hold wins over flush
      ex_out <= bubble;
    end else if (!hold) begin
      ex_out <= id_in;
    end
  end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
/*
 * Execute stage: ALU, branch resolution, iterative multiplier
 * Forwarding bus, registered write-back and redirect strobes
 */

`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module execute_stage (
  input  wire                        clk,
  input  wire                        reset_n,
  input  wire rv_pipe_pkg::idex_t    ex_in,
  output logic                       hold,
  output logic                       flush,
  output rv_pipe_pkg::fwd_t          fwd,
  output rv_pipe_pkg::wb_t           wb,
  output rv_pipe_pkg::redirect_t     redirect
);

  import rv_pipe_pkg::*;

  localparam int CNT_W = $clog2(`MUL_CYCLES);
  localparam int CHUNK = (`XLEN + `MUL_CYCLES - 1) / `MUL_CYCLES;  // Multiplier bits per cycle
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`MUL_CYCLES - 1);

  logic [`XLEN-1:0] src_b;
  logic [`XLEN-1:0] alu_res;
  logic             is_mul;
  logic             mul_last;
  logic [CNT_W-1:0] mul_cnt;
  logic [`XLEN-1:0] mul_acc;
  logic [`XLEN-1:0] mul_part;
  logic [`XLEN-1:0] mul_sum;
  logic             taken;

  assign src_b = ex_in.alu_src ? ex_in.imm : ex_in.op_b;

  always_comb begin
    case (ex_in.alu_op)
      ALU_ADD: alu_res = ex_in.op_a + src_b;
      ALU_SUB: alu_res = ex_in.op_a - src_b;
      ALU_AND: alu_res = ex_in.op_a & src_b;
      ALU_OR:  alu_res = ex_in.op_a | src_b;
      ALU_XOR: alu_res = ex_in.op_a ^ src_b;
      ALU_SLT: alu_res = {{(`XLEN-1){1'b0}}, $signed(ex_in.op_a) < $signed(src_b)};
      default: alu_res = '0;  // MUL result comes from mul_sum
    endcase
  end

  assign is_mul   = ex_in.valid && (ex_in.alu_op == ALU_MUL);
  assign mul_last = is_mul && (mul_cnt == CNT_LAST);
  assign hold     = is_mul && !mul_last;

  // One CHUNK of the multiplier per cycle, operands stay put under hold
  always_comb begin : mul_step
    logic [`XLEN-1:0] mcand;
    logic [CHUNK-1:0] mbits;
    mcand    = ex_in.op_a << (mul_cnt * CHUNK);
    mbits    = CHUNK'(ex_in.op_b >> (mul_cnt * CHUNK));
    mul_part = '0;
    for (int j = 0; j < CHUNK; j++) begin
      if (mbits[j]) begin
        mul_part = mul_part + (mcand << j);
      end
    end
  end

  assign mul_sum = ((mul_cnt == '0) ? '0 : mul_acc) + mul_part;  // Low XLEN bits only

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mul_cnt <= '0;
      mul_acc <= '0;
    end else if (is_mul) begin
      mul_cnt <= mul_last ? '0 : mul_cnt + 1'b1;
      mul_acc <= mul_sum;
    end else begin
      mul_cnt <= '0;
    end
  end

  // BEQ on equal, BNE on unequal
  assign taken = ex_in.valid && ex_in.branch &&
                 ((ex_in.op_a == ex_in.op_b) != ex_in.branch_ne);
  assign flush = taken;

  always_comb begin
    fwd.valid = ex_in.valid && ex_in.reg_write && (!is_mul || mul_last);
    fwd.rd    = ex_in.rd;
    fwd.data  = is_mul ? mul_sum : alu_res;
  end

  // One-cycle strobes
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wb       <= '0;
      redirect <= '0;
    end else begin
      wb.valid        <= fwd.valid;
      wb.rd           <= fwd.rd;
      wb.data         <= fwd.data;
      redirect.valid  <= taken;
      redirect.target <= ex_in.pc + ex_in.imm;
    end
  end

endmodule

`default_nettype wire

// File: design/rv_core_top.sv
/*
 * Decode-to-execute core slice
 * Register file, decode, ID/EX register and execute stage
 */

`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module rv_core_top (
  input  wire                          clk,
  input  wire                          reset_n,
  input  wire                          instr_valid,
  input  wire [`XLEN-1:0]              instr_pc,
  input  wire rv_isa_pkg::instr_u      instr_word,
  output wire                          ready,
  output wire rv_pipe_pkg::wb_t        wb,
  output wire rv_pipe_pkg::redirect_t  redirect
);

  import rv_pipe_pkg::*;

  wire [`REG_ADDR_W-1:0] rs1_addr;
  wire [`REG_ADDR_W-1:0] rs2_addr;
  wire [`XLEN-1:0]       rs1_data;
  wire [`XLEN-1:0]       rs2_data;
  wire idex_t            id_bus;  // Decode to ID/EX
  wire idex_t            ex_bus;  // ID/EX to execute
  wire fwd_t             fwd;
  wire                   hold;
  wire                   flush;

  assign ready = ~hold;  // Stalled only by a running multiply

  reg_file u_reg_file (
    .clk      (clk),
    .reset_n  (reset_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr       (fwd)
  );

  decode_stage u_decode (
    .instr_valid (instr_valid),
    .ready       (ready),
    .instr_pc    (instr_pc),
    .instr_word  (instr_word),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .fwd         (fwd),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .id_out      (id_bus)
  );

  idex_register u_idex (
    .clk     (clk),
    .reset_n (reset_n),
    .hold    (hold),
    .flush   (flush),
    .id_in   (id_bus),
    .ex_out  (ex_bus)
  );

  execute_stage u_execute (
    .clk      (clk),
    .reset_n  (reset_n),
    .ex_in    (ex_bus),
    .hold     (hold),
    .flush    (flush),
    .fwd      (fwd),
    .wb       (wb),
    .redirect (redirect)
  );

endmodule

`default_nettype wire

// File: bench/core_asserts.sv
/*
 * Concurrent checks on the core top level
 * Strobe exclusion, ready after reset, quiet stall cycles
 */

`timescale 1ns/1ps
`default_nettype none

module core_asserts (
  input wire                         clk,
  input wire                         reset_n,
  input wire                         ready,
  input wire rv_pipe_pkg::wb_t       wb,
  input wire rv_pipe_pkg::redirect_t redirect
);

  // An instruction is either a write or a branch, never both
  a_one_strobe: assert property (
    @(posedge clk) disable iff (!reset_n)
    !(wb.valid && redirect.valid)
  ) else $error("wb and redirect strobes high in the same cycle");

  a_ready_after_reset: assert property (
    @(posedge clk) $rose(reset_n) |-> ready
  ) else $error("ready low in the first cycle after reset");

  // A stall cycle completes nothing, so no strobe follows it
  a_stall_quiet: assert property (
    @(posedge clk) disable iff (!reset_n)
    !ready |=> !wb.valid
  ) else $error("wb strobe after a stalled multiply cycle");

endmodule

`default_nettype wire

// File: bench/core_tb.sv
/*
 * Testbench for the decode-to-execute core slice
 * Stimulus, reference model, compare tasks, watchdog
 */

`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module core_tb;

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  localparam int TOTAL_INSTR = 420;
  localparam int LIMIT_NS    = TOTAL_INSTR * (`MUL_CYCLES + 2) * 10 + 5000;

  logic             clk;
  logic             reset_n;
  logic             instr_valid;
  logic [`XLEN-1:0] instr_pc;
  instr_u           instr_word;
  logic             ready;
  wb_t              wb;
  redirect_t        redirect;

  logic [`XLEN-1:0] shadow [32];  // Reference register file
  wb_t              exp_wb_q [$];
  int               wb_due_q [$];
  redirect_t        exp_rd_q [$];
  int               rd_due_q [$];
  int               cyc;
  int               errors;
  int               checks;
  int               tests;
  int               stall_left;
  int               squash_cycle;
  logic [`XLEN-1:0] pc_next;

  rv_core_top dut (
    .clk         (clk),
    .reset_n     (reset_n),
    .instr_valid (instr_valid),
    .instr_pc    (instr_pc),
    .instr_word  (instr_word),
    .ready       (ready),
    .wb          (wb),
    .redirect    (redirect)
  );

  bind rv_core_top core_asserts u_asserts (
    .clk      (clk),
    .reset_n  (reset_n),
    .ready    (ready),
    .wb       (wb),
    .redirect (redirect)
  );

  always #5 clk = ~clk;

  // Kind 0 nothing, 1 write-back, 2 redirect, 3 write-back after a multiply
  function automatic int model_exec(input instr_u w, input logic [`XLEN-1:0] pc,
                                    output wb_t ew, output redirect_t er);
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] res;
    logic [`XLEN-1:0] imm;
    int               kind;
    ew   = '0;
    er   = '0;
    kind = 0;
    res  = '0;
    a    = shadow[w.r.rs1];
    b    = shadow[w.r.rs2];
    case (w.r.opcode)
      OP_REG: begin
        kind = 1;
        case ({w.r.funct7, w.r.funct3})
          {F7_BASE, F3_ADD}: res = a + b;
          {F7_SUB, F3_ADD}:  res = a - b;
          {F7_BASE, F3_AND}: res = a & b;
          {F7_BASE, F3_OR}:  res = a | b;
          {F7_BASE, F3_XOR}: res = a ^ b;
          {F7_BASE, F3_SLT}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          {F7_MUL, F3_ADD}: begin
            res  = a * b;  // Low word only
            kind = 3;
          end
          default: kind = 0;
        endcase
      end
      OP_IMM: begin
        if (w.r.funct3 == F3_ADD) begin
          imm  = {{20{w[31]}}, w[31:20]};
          res  = a + imm;
          kind = 1;
        end
      end
      OP_BRANCH: begin
        imm       = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        er.valid  = 1'b1;
        er.target = pc + imm;
        if ((w.r.funct3 == F3_BEQ && a == b) || (w.r.funct3 == F3_BNE && a != b)) begin
          kind = 2;
        end
      end
      default: ;
    endcase
    if (kind == 1 || kind == 3) begin
      ew.valid = 1'b1;
      ew.rd    = w.r.rd;
      ew.data  = res;
      if (w.r.rd != 5'd0) begin
        shadow[w.r.rd] = res;
      end
    end
    return kind;
  endfunction

  task automatic check_wb(input wb_t got, input wb_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: wb rd %0d data %08h, expected rd %0d data %08h",
               $time, got.rd, got.data, exp.rd, exp.data);
    end
  endtask

  task automatic check_redirect(input redirect_t got, input redirect_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: redirect target %08h, expected %08h",
               $time, got.target, exp.target);
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: ready %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic compare_outputs();
    logic wb_due;
    logic rd_due;
    wb_due = (wb_due_q.size() > 0) && (wb_due_q[0] == cyc);
    rd_due = (rd_due_q.size() > 0) && (rd_due_q[0] == cyc);
    if (wb.valid && redirect.valid) begin
      errors++;
      $display("Write-back and redirect strobes were high together at %0t", $time);
    end
    if (wb.valid && !wb_due) begin
      errors++;
      $display("Unexpected write-back strobe at %0t for rd %0d", $time, wb.rd);
    end else if (wb_due) begin
      if (!wb.valid) begin
        errors++;
        $display("A write-back strobe was missing at %0t", $time);
      end else begin
        check_wb(wb, exp_wb_q[0]);
      end
      void'(exp_wb_q.pop_front());
      void'(wb_due_q.pop_front());
    end
    if (redirect.valid && !rd_due) begin
      errors++;
      $display("Unexpected redirect strobe at %0t", $time);
    end else if (rd_due) begin
      if (!redirect.valid) begin
        errors++;
        $display("A redirect strobe was missing at %0t", $time);
      end else begin
        check_redirect(redirect, exp_rd_q[0]);
      end
      void'(exp_rd_q.pop_front());
      void'(rd_due_q.pop_front());
    end
  endtask

  // Records acceptances and queues the expected results in order
  task automatic track_accept();
    wb_t       ew;
    redirect_t er;
    int        kind;
    if (instr_valid && ready && cyc != squash_cycle) begin
      kind = model_exec(instr_word, instr_pc, ew, er);
      if (kind == 1 || kind == 3) begin
        exp_wb_q.push_back(ew);
        wb_due_q.push_back(cyc + ((kind == 3) ? `MUL_CYCLES + 1 : 2));
      end else if (kind == 2) begin
        exp_rd_q.push_back(er);
        rd_due_q.push_back(cyc + 2);
        squash_cycle = cyc + 1;  // Next edge's instruction is flushed
      end
      if (kind == 3) begin
        stall_left = `MUL_CYCLES - 1;  // EX holds the multiply
      end
    end
  endtask

  // Ready low for the held cycles of each multiply, high otherwise
  task automatic track_ready();
    check_ready(ready, stall_left == 0);
    if (stall_left > 0) begin
      stall_left--;
    end
  endtask

  always @(posedge clk) begin
    if (reset_n) begin
      compare_outputs();
      track_ready();
      track_accept();
    end
    cyc = cyc + 1;
  end

  function automatic instr_u enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                   input logic [4:0] rd, input logic [4:0] rs1,
                                   input logic [4:0] rs2);
    instr_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = OP_REG;
    return w;
  endfunction

  function automatic instr_u enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [4:0] rd);
    instr_u w;
    w.ib.imm_hi     = imm[11:5];
    w.ib.rs2_or_imm = imm[4:0];
    w.ib.rs1        = rs1;
    w.ib.funct3     = F3_ADD;
    w.ib.rd_or_imm  = rd;
    w.ib.opcode     = OP_IMM;
    return w;
  endfunction

  function automatic instr_u enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                   input logic [4:0] rs2, input logic [12:0] imm);
    instr_u w;
    w.ib.imm_hi     = {imm[12], imm[10:5]};
    w.ib.rs2_or_imm = rs2;
    w.ib.rs1        = rs1;
    w.ib.funct3     = f3;
    w.ib.rd_or_imm  = {imm[4:1], imm[11]};
    w.ib.opcode     = OP_BRANCH;
    return w;
  endfunction

  // 0 ADD, 1 SUB, 2 AND, 3 OR, 4 XOR, 5 SLT, 6 MUL
  function automatic instr_u r_op(input int op, input logic [4:0] rd,
                                  input logic [4:0] rs1, input logic [4:0] rs2);
    case (op)
      1:       return enc_r(F7_SUB, F3_ADD, rd, rs1, rs2);
      2:       return enc_r(F7_BASE, F3_AND, rd, rs1, rs2);
      3:       return enc_r(F7_BASE, F3_OR, rd, rs1, rs2);
      4:       return enc_r(F7_BASE, F3_XOR, rd, rs1, rs2);
      5:       return enc_r(F7_BASE, F3_SLT, rd, rs1, rs2);
      6:       return enc_r(F7_MUL, F3_ADD, rd, rs1, rs2);
      default: return enc_r(F7_BASE, F3_ADD, rd, rs1, rs2);
    endcase
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'($urandom % 8);  // Small set so dependencies are frequent
  endfunction

  function automatic instr_u random_instr();
    int sel;
    sel = $urandom % 10;
    if (sel < 6) begin
      return r_op(int'($urandom % 6), rand_reg(), rand_reg(), rand_reg());
    end else if (sel < 8) begin
      return enc_i(12'($urandom), rand_reg(), rand_reg());
    end else if (sel == 8) begin
      return r_op(6, rand_reg(), rand_reg(), rand_reg());
    end
    return enc_b(($urandom % 2 == 0) ? F3_BEQ : F3_BNE, rand_reg(), rand_reg(),
                 13'($urandom) & 13'h1ffe);
  endfunction

  // Returns right after the acceptance edge
  task automatic issue_instr(input instr_u w, input int gap);
    if (gap > 0) begin
      instr_valid <= 1'b0;
      repeat (gap) @(posedge clk);
    end
    instr_valid <= 1'b1;
    instr_word  <= w;
    instr_pc    <= pc_next;
    pc_next      = pc_next + 32'd4;
    do @(posedge clk); while (!ready);
  endtask

  task automatic idle(input int n);
    instr_valid <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  task automatic drain();
    int n;
    instr_valid <= 1'b0;
    n = 0;
    while ((wb_due_q.size() > 0 || rd_due_q.size() > 0) && n < `MUL_CYCLES + 8) begin
      @(posedge clk);
      n++;
    end
    if (wb_due_q.size() > 0 || rd_due_q.size() > 0) begin
      errors++;
      $display("Expected strobes were still pending at %0t", $time);
    end
    idle(2);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    $display("Test %-12s done, %0d errors", name, errors - err_before);
  endtask

  initial begin : watchdog
    #(LIMIT_NS);
    $display("Timeout: the run did not finish within %0d ns", LIMIT_NS);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : stimulus
    int         eb;
    logic [4:0] r;
    logic [4:0] nr;
    void'($urandom(32'h3e25bbf6));
    clk          = 1'b0;
    reset_n     <= 1'b0;
    instr_valid <= 1'b0;
    instr_pc    <= '0;
    instr_word  <= '0;
    cyc          = 0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    stall_left   = 0;
    squash_cycle = -1;
    pc_next      = 32'h100;
    for (int i = 0; i < 32; i++) begin
      shadow[i] = '0;
    end
    repeat (5) @(posedge clk);
    reset_n <= 1'b1;
    @(posedge clk);

    eb = errors;
    check_ready(ready, 1'b1);
    idle(10);
    finish_test("reset", eb);

    eb = errors;
    for (int i = 1; i < 8; i++) begin
      issue_instr(enc_i(12'($urandom), 5'd0, 5'(i)), 1);
    end
    for (int op = 0; op < 6; op++) begin
      repeat (3) issue_instr(r_op(op, rand_reg(), rand_reg(), rand_reg()), 1);
    end
    issue_instr(enc_i(12'h7ff, 5'd3, 5'd0), 1);  // Result dropped by x0
    issue_instr(r_op(0, 5'd9, 5'd0, 5'd0), 1);
    drain();
    finish_test("alu", eb);

    eb = errors;
    r = 5'd1;
    repeat (20) begin
      nr = 5'((r % 7) + 1);
      issue_instr(r_op(int'($urandom % 6), nr, r, rand_reg()), 0);
      r = nr;
    end
    drain();
    finish_test("dependency", eb);

    eb = errors;
    for (int i = 1; i < 8; i++) begin
      issue_instr(enc_i(12'($urandom), 5'(i), 5'(i)), 0);
    end
    repeat (10) begin
      nr = rand_reg();
      issue_instr(r_op(6, nr, rand_reg(), rand_reg()), 0);
      issue_instr(r_op(0, rand_reg(), nr, nr), 0);  // Waits through the hold
    end
    drain();
    finish_test("multiply", eb);

    eb = errors;
    issue_instr(enc_i(12'd5, 5'd0, 5'd7), 1);
    issue_instr(enc_b(F3_BNE, 5'd7, 5'd0, 13'h0040), 0);  // Taken
    issue_instr(r_op(0, 5'd6, 5'd7, 5'd7), 0);             // Squashed
    issue_instr(enc_b(F3_BEQ, 5'd7, 5'd0, 13'h1ff0), 0);  // Not taken
    issue_instr(r_op(0, 5'd6, 5'd7, 5'd7), 0);
    issue_instr(enc_b(F3_BEQ, 5'd6, 5'd6, 13'h1fe0), 0);  // Taken, backward
    issue_instr(r_op(1, 5'd5, 5'd6, 5'd7), 0);
    drain();
    finish_test("branch", eb);

    eb = errors;
    repeat (300) begin
      issue_instr(random_instr(), int'($urandom % 3));
    end
    drain();
    finish_test("random", eb);

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+design
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/reg_file.sv
design/decode_stage.sv
design/idex_register.sv
design/execute_stage.sv
design/rv_core_top.sv
bench/core_asserts.sv
bench/core_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator, then search the log for the pass line
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --assert -f all.f --top-module core_tb -o core_sim > build.log 2>&1 \
  && ./obj_dir/core_sim > sim.log 2>&1 \
  || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "^Result: PASSED$" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed, see sim.log"; exit 1; }
